/* project.f */
verilog/msr_pkg.sv
verilog/msr_issue.sv
verilog/msr_eu.sv
verilog/msr_file.sv
verilog/msr_unit.sv
tb/tb_clock.sv
tb/msr_unit_asserts.sv
tb/msr_unit_tb.sv

/* tb/msr_unit_asserts.sv */
// MSR execute stage assertions
`timescale 1ns/1ps
`default_nettype none

module msr_unit_asserts
   import msr_pkg::*;
(
   input wire logic      clk,
   input wire logic      reset,
   input wire msr_addr_t s_addr,
   input wire logic      s_rmsr,
   input wire logic      s_wmsr,
   input wire logic      s_commit,
   input wire logic      s_cc_we,
   input wire logic      s_ret,
   input wire logic      s_let_lsa_pc,
   input wire logic      rd_valid
);

   logic wr_psr;
   logic wr_elsa;

   assign wr_psr  = s_wmsr & (s_addr.ps.bank == bank_ps) & s_addr.ps.off[off_psr];
   assign wr_elsa = s_wmsr & (s_addr.ps.bank == bank_ps) & s_addr.ps.off[off_elsa];

   // One status source per committed op
   status_src_excl: assert property (@(posedge clk) disable iff (reset)
      s_commit |-> $onehot0({s_cc_we, wr_psr, s_ret}))
      else $error("status write-back controls overlap under commit");

   elsa_src_excl: assert property (@(posedge clk) disable iff (reset)
      s_commit |-> !(s_let_lsa_pc && wr_elsa))
      else $error("both ELSA sources active in one cycle");

   // Read result one cycle behind the staged strobe
   rd_valid_follows: assert property (@(posedge clk) disable iff (reset)
      s_rmsr |=> rd_valid)
      else $error("rd_valid missing one cycle after staged rmsr");

   rd_valid_quiet: assert property (@(posedge clk) disable iff (reset)
      !s_rmsr |=> !rd_valid)
      else $error("rd_valid high without a staged rmsr");

endmodule

`default_nettype wire

/* tb/msr_unit_tb.sv */
// MSR unit testbench
`timescale 1ns/1ps
`default_nettype none

module msr_unit_tb
   import msr_pkg::*;
();

   typedef struct {
      string             name;
      int                due;
      logic              rd_chk;
      logic [msr_dw-1:0] rd;
      logic [psr_dw-1:0] psr;
      logic [msr_dw-1:0] epc;
      logic              exp_ent;
   } result_t;

   logic              clk;
   logic              reset;
   logic              rmsr;
   logic              wmsr;
   logic [msr_dw-1:0] operand_1;
   logic [msr_dw-1:0] operand_2;
   logic [msr_dw-1:0] operand_3;
   logic              commit;
   logic              cc_we;
   logic              cc_nxt;
   logic              ret;
   logic              syscall;
   logic              ext_exp;
   logic              let_lsa_pc;
   logic [msr_dw-3:0] insn_pc;
   logic [msr_dw-1:0] rd_data;
   logic              rd_valid;
   logic              exp_ent;
   logic [psr_dw-1:0] psr;
   logic [msr_dw-1:0] epc;

   // Model of the register state
   logic [psr_dw-1:0] m_psr;
   logic [psr_dw-1:0] m_epsr;
   logic [msr_dw-1:0] m_epc;
   logic [msr_dw-1:0] m_elsa;
   logic [msr_dw-1:0] m_tlbl [16];
   logic [msr_dw-1:0] m_tlbh [16];

   result_t pending[$];
   int      cyc = 0;

   tb_clock clock0 (.clk(clk));

   msr_unit dut0 (
      .clk        (clk),
      .reset      (reset),
      .rmsr       (rmsr),
      .wmsr       (wmsr),
      .operand_1  (operand_1),
      .operand_2  (operand_2),
      .operand_3  (operand_3),
      .commit     (commit),
      .cc_we      (cc_we),
      .cc_nxt     (cc_nxt),
      .ret        (ret),
      .syscall    (syscall),
      .ext_exp    (ext_exp),
      .let_lsa_pc (let_lsa_pc),
      .insn_pc    (insn_pc),
      .rd_data    (rd_data),
      .rd_valid   (rd_valid),
      .exp_ent    (exp_ent),
      .psr        (psr),
      .epc        (epc)
   );

   bind msr_eu msr_unit_asserts asserts0 (
      .clk          (clk),
      .reset        (reset),
      .s_addr       (s_addr),
      .s_rmsr       (s_rmsr),
      .s_wmsr       (s_wmsr),
      .s_commit     (s_commit),
      .s_cc_we      (s_cc_we),
      .s_ret        (s_ret),
      .s_let_lsa_pc (s_let_lsa_pc),
      .rd_valid     (rd_valid)
   );

   always @(posedge clk)
      cyc <= cyc + 1;

   function automatic logic [msr_dw-1:0] bank_addr(input logic [3:0] bank,
                                                    input logic [8:0] off);
      return {19'd0, bank, off};
   endfunction

   function automatic logic [msr_dw-1:0] tlb_addr(input logic sel, input logic high,
                                                   input logic [3:0] idx);
      return {19'd0, bank_imm, sel, high, 3'b000, idx};
   endfunction

   // Expected outcome of the operation now on the inputs
   // Also advances the register model
   function automatic result_t model_step(input string name);
      result_t           r;
      logic [msr_dw-1:0] a;
      logic [8:0]        off;
      logic [3:0]        idx;
      logic [msr_dw-1:0] pc4;
      logic              ps;
      logic              im;
      logic [psr_dw-1:0] old_psr;
      logic [psr_dw-1:0] old_epsr;
      a = operand_1 + operand_2;
      off = a[8:0];
      idx = a[3:0];
      ps = (a[12:9] == 4'd0);
      im = (a[12:9] == 4'd1);
      pc4 = {insn_pc, 2'b00};
      old_psr = m_psr;
      old_epsr = m_epsr;
      r.name = name;
      r.due = cyc + 2;
      r.rd_chk = rmsr;
      r.exp_ent = commit & (syscall | ext_exp);
      // Read sees the state before this operation
      r.rd = '0;
      if (ps) begin
         if (off[off_psr])
            r.rd |= {22'd0, m_psr};
         if (off[off_cpuid])
            r.rd |= cpuid_val;
         if (off[off_epsr])
            r.rd |= {22'd0, m_epsr};
         if (off[off_epc])
            r.rd |= m_epc;
         if (off[off_elsa])
            r.rd |= m_elsa;
         if (off[off_coreid])
            r.rd |= coreid_val;
      end else if (im) begin
         if (!a[8])
            r.rd = immid_val;
         else if (a[7])
            r.rd = m_tlbh[idx];
         else
            r.rd = m_tlbl[idx];
      end
      if (commit) begin
         if (cc_we)
            m_psr[0] = cc_nxt;
         else if (wmsr && ps && off[off_psr])
            m_psr[0] = operand_3[0];
         else if (ret)
            m_psr[0] = old_epsr[0];
         // rm, ire, imme, dmme
         if (wmsr && ps && off[off_psr])
            m_psr[7:4] = operand_3[7:4];
         else if (ret)
            m_psr[7:4] = old_epsr[7:4];
         if (wmsr && ps && off[off_epsr])
            m_epsr = operand_3[psr_dw-1:0];
         else if (syscall || ext_exp)
            m_epsr = old_psr;
         if (wmsr && ps && off[off_epc])
            m_epc = operand_3;
         else if (ext_exp)
            m_epc = pc4;
         else if (syscall)
            m_epc = pc4 + 32'd4;
         if (let_lsa_pc)
            m_elsa = pc4;
         else if (wmsr && ps && off[off_elsa])
            m_elsa = operand_3;
         if (wmsr && im && a[8]) begin
            if (a[7])
               m_tlbh[idx] = operand_3;
            else
               m_tlbl[idx] = operand_3;
         end
      end
      r.psr = m_psr;
      r.epc = m_epc;
      return r;
   endfunction

   task automatic compare(input string name, input string what,
                          input logic [msr_dw-1:0] exp, input logic [msr_dw-1:0] act);
      assert (act === exp) else begin
         $display("Mismatch %s %s expected %h actual %h", name, what, exp, act);
         $display("SIMULATION FAILED");
         $fatal(1);
      end
   endtask

   // Results land one cycle after the DUT samples the op
   always @(negedge clk) begin : compare_results
      result_t e;
      if (!reset) begin
         while (pending.size() != 0 && pending[0].due == cyc) begin
            e = pending.pop_front();
            compare(e.name, "rd_valid", e.rd_chk, rd_valid);
            if (e.rd_chk)
               compare(e.name, "rd_data", e.rd, rd_data);
            compare(e.name, "exp_ent", e.exp_ent, exp_ent);
            compare(e.name, "psr", e.psr, psr);
            compare(e.name, "epc", e.epc, epc);
         end
      end
   end

   task automatic begin_op();
      @(negedge clk);
      rmsr = 1'b0;
      wmsr = 1'b0;
      commit = 1'b1;
      cc_we = 1'b0;
      cc_nxt = 1'b0;
      ret = 1'b0;
      syscall = 1'b0;
      ext_exp = 1'b0;
      let_lsa_pc = 1'b0;
      operand_1 = $urandom;
      operand_2 = $urandom;
      operand_3 = $urandom;
      insn_pc = (msr_dw-2)'($urandom);
   endtask

   task automatic split_addr(input logic [msr_dw-1:0] addr);
      operand_2 = $urandom;
      operand_1 = addr - operand_2;
   endtask

   task automatic idle_cycle(input string name);
      begin_op();
      pending.push_back(model_step(name));
   endtask

   task automatic read_msr(input string name, input logic [msr_dw-1:0] addr);
      begin_op();
      rmsr = 1'b1;
      split_addr(addr);
      pending.push_back(model_step(name));
   endtask

   task automatic write_msr(input string name, input logic [msr_dw-1:0] addr,
                            input logic [msr_dw-1:0] data, input logic c);
      begin_op();
      wmsr = 1'b1;
      commit = c;
      split_addr(addr);
      operand_3 = data;
      pending.push_back(model_step(name));
   endtask

   task automatic retire_ctrl(input string name, input string which, input logic v,
                              input logic c);
      begin_op();
      commit = c;
      case (which)
         "syscall": syscall = 1'b1;
         "ext_exp": ext_exp = 1'b1;
         "ret":     ret = 1'b1;
         "lsa":     let_lsa_pc = 1'b1;
         default: begin
            cc_we = 1'b1;
            cc_nxt = v;
         end
      endcase
      pending.push_back(model_step(name));
   endtask

   initial begin : stimulus
      int                kind;
      int                guard;
      int                wr_offs[4];
      logic [msr_dw-1:0] wr_data;
      void'($urandom(94));
      wr_offs = '{off_psr, off_epsr, off_epc, off_elsa};
      reset = 1'b1;
      rmsr = 1'b0;
      wmsr = 1'b0;
      operand_1 = '0;
      operand_2 = '0;
      operand_3 = '0;
      commit = 1'b0;
      cc_we = 1'b0;
      cc_nxt = 1'b0;
      ret = 1'b0;
      syscall = 1'b0;
      ext_exp = 1'b0;
      let_lsa_pc = 1'b0;
      insn_pc = '0;
      m_psr = psr_reset;
      m_epsr = '0;
      m_epc = '0;
      m_elsa = '0;
      for (int i = 0; i < 16; i++) begin
         m_tlbl[i] = '0;
         m_tlbh[i] = '0;
      end
      repeat (2) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      // Reset values and constants
      for (int i = 0; i < 6; i++)
         read_msr($sformatf("reset_ps_%0d", i), bank_addr(bank_ps, 9'(1 << i)));
      read_msr("reset_immid", tlb_addr(1'b0, 1'b0, 4'd0));
      read_msr("reset_or", bank_addr(bank_ps, 9'h023));

      // PS bank writes, reads and blocked writes back to back
      // A blocked write carries the complement so every bit would show
      foreach (wr_offs[i]) begin
         wr_data = $urandom | 32'hffff_fc00;
         write_msr("ps_write", bank_addr(bank_ps, 9'(1 << wr_offs[i])), wr_data, 1'b1);
         read_msr("ps_readback", bank_addr(bank_ps, 9'(1 << wr_offs[i])));
         write_msr("ps_blocked", bank_addr(bank_ps, 9'(1 << wr_offs[i])), ~wr_data, 1'b0);
         read_msr("ps_blocked_read", bank_addr(bank_ps, 9'(1 << wr_offs[i])));
      end

      // TLB arrays
      for (int i = 0; i < 24; i++)
         write_msr("tlb_write", tlb_addr(1'b1, 1'($urandom), 4'($urandom)), $urandom, 1'b1);
      for (int i = 0; i < 32; i++)
         read_msr("tlb_read", tlb_addr(1'b1, i[4], i[3:0]));
      read_msr("tlb_immid", tlb_addr(1'b0, 1'($urandom), 4'($urandom)));
      for (int b = 2; b < 16; b++) begin
         write_msr("unmapped_write", bank_addr(4'(b), 9'h1ff), 32'hffff_ffff, 1'b1);
         read_msr("unmapped_read", bank_addr(4'(b), 9'h1ff));
      end
      read_msr("after_unmapped", bank_addr(bank_ps, 9'h01d));

      // Exception entry
      write_msr("exc_setup_psr", bank_addr(bank_ps, 9'h001), 32'h0000_00f1, 1'b1);
      retire_ctrl("syscall", "syscall", 1'b0, 1'b1);
      read_msr("syscall_epsr", bank_addr(bank_ps, 9'h004));
      read_msr("syscall_epc", bank_addr(bank_ps, 9'h008));
      retire_ctrl("ext_exp", "ext_exp", 1'b0, 1'b1);
      read_msr("ext_exp_epc", bank_addr(bank_ps, 9'h008));

      // Return and flag updates
      write_msr("ret_setup_epsr", bank_addr(bank_ps, 9'h004), 32'h0000_03a1, 1'b1);
      write_msr("ret_setup_psr", bank_addr(bank_ps, 9'h001), 32'h0000_0050, 1'b1);
      retire_ctrl("ret", "ret", 1'b0, 1'b1);
      read_msr("ret_psr", bank_addr(bank_ps, 9'h001));
      retire_ctrl("cc_set", "cc", 1'b1, 1'b1);
      retire_ctrl("cc_clear", "cc", 1'b0, 1'b1);
      retire_ctrl("cc_blocked", "cc", 1'b1, 1'b0);
      read_msr("cc_psr", bank_addr(bank_ps, 9'h001));
      retire_ctrl("lsa", "lsa", 1'b0, 1'b1);
      read_msr("lsa_elsa", bank_addr(bank_ps, 9'h010));

      // Random mix of one operation per cycle
      for (int i = 0; i < 400; i++) begin
         kind = $urandom_range(8, 0);
         case (kind)
            0: read_msr("mix_read", bank_addr(4'($urandom_range(2, 0)), 9'($urandom)));
            1: write_msr("mix_write", bank_addr(4'($urandom_range(2, 0)), 9'($urandom)),
                         $urandom, $urandom_range(7, 0) != 0);
            2: retire_ctrl("mix_syscall", "syscall", 1'b0, $urandom_range(7, 0) != 0);
            3: retire_ctrl("mix_ext_exp", "ext_exp", 1'b0, $urandom_range(7, 0) != 0);
            4: retire_ctrl("mix_ret", "ret", 1'b0, $urandom_range(7, 0) != 0);
            5: retire_ctrl("mix_cc", "cc", 1'($urandom), $urandom_range(7, 0) != 0);
            6: retire_ctrl("mix_lsa", "lsa", 1'b0, $urandom_range(7, 0) != 0);
            7: idle_cycle("mix_idle");
            default: read_msr("mix_read_all", bank_addr(bank_ps, 9'h03f));
         endcase
      end

      idle_cycle("drain");
      guard = 0;
      while (pending.size() != 0 && guard < 8) begin
         @(negedge clk);
         guard++;
      end
      if (pending.size() != 0) begin
         $display("Timeout: %0d results were never compared", pending.size());
         $display("SIMULATION FAILED");
         $fatal(1);
      end else begin
         $display("SIMULATION PASSED");
         $finish;
      end
   end

endmodule

`default_nettype wire

/* tb/tb_clock.sv */
// Testbench clock source
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
   output logic clk
);

   // 4 ns period
   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

endmodule

`default_nettype wire

/* verilog/msr_eu.sv */
// MSR execute stage
`timescale 1ns/1ps
`default_nettype none

module msr_eu
   import msr_pkg::*;
(
   input  wire logic              clk,
   input  wire logic              reset,
   input  wire msr_addr_t         s_addr,
   input  wire logic              s_rmsr,
   input  wire logic              s_wmsr,
   input  wire logic [msr_dw-1:0] s_wdata,
   input  wire logic              s_commit,
   input  wire logic              s_cc_we,
   input  wire logic              s_cc_nxt,
   input  wire logic              s_ret,
   input  wire logic              s_syscall,
   input  wire logic              s_ext_exp,
   input  wire logic              s_let_lsa_pc,
   input  wire logic [msr_dw-3:0] s_pc,
   // Current register values
   input  wire logic [psr_dw-1:0] psr,
   input  wire logic [psr_dw-1:0] epsr,
   input  wire logic [msr_dw-1:0] epc,
   input  wire logic [msr_dw-1:0] elsa,
   input  wire logic [msr_dw-1:0] tlbl_q,
   input  wire logic [msr_dw-1:0] tlbh_q,
   // Write-back
   output logic [tlb_aw-1:0]      tlb_idx,
   output logic [psr_dw-1:0]      psr_nxt,
   // Bit 0 cc, 1 rm, 2 ire, 3 imme, 4 dmme
   output logic [4:0]             psr_field_we,
   output logic [psr_dw-1:0]      epsr_nxt,
   output logic                   epsr_we,
   output logic [msr_dw-1:0]      epc_nxt,
   output logic                   epc_we,
   output logic [msr_dw-1:0]      elsa_nxt,
   output logic                   elsa_we,
   output logic                   tlbl_we,
   output logic                   tlbh_we,
   output logic [msr_dw-1:0]      wdata,
   // Results
   output logic [msr_dw-1:0]      rd_data,
   output logic                   rd_valid,
   output logic                   exp_ent
);

   logic              is_ps;
   logic              is_imm;
   logic              tlbl_sel;
   logic              tlbh_sel;
   logic [msr_dw-1:0] dout_ps;
   logic [msr_dw-1:0] dout_imm;
   logic [msr_dw-1:0] rd_mux;
   logic              wmsr_psr;
   logic              wmsr_epsr;
   logic              wmsr_epc;
   logic              wmsr_elsa;
   logic              exp_ent_c;
   logic [msr_dw-1:0] pc_addr;

   assign is_ps    = (s_addr.ps.bank == bank_ps);
   assign is_imm   = (s_addr.ps.bank == bank_imm);
   assign tlbl_sel = s_addr.imm.tlbsel & ~s_addr.imm.tlbh_sel;
   assign tlbh_sel = s_addr.imm.tlbsel & s_addr.imm.tlbh_sel;
   assign tlb_idx  = s_addr.imm.idx;

   // Offsets are one-hot selects, so multiple hits OR together
   assign dout_ps =
      ({msr_dw{s_addr.ps.off[off_psr]}}    & {{(msr_dw-psr_dw){1'b0}}, psr})  |
      ({msr_dw{s_addr.ps.off[off_cpuid]}}  & cpuid_val)                       |
      ({msr_dw{s_addr.ps.off[off_epsr]}}   & {{(msr_dw-psr_dw){1'b0}}, epsr}) |
      ({msr_dw{s_addr.ps.off[off_epc]}}    & epc)                             |
      ({msr_dw{s_addr.ps.off[off_elsa]}}   & elsa)                            |
      ({msr_dw{s_addr.ps.off[off_coreid]}} & coreid_val);

   assign dout_imm =
      ({msr_dw{~s_addr.imm.tlbsel}} & immid_val) |
      ({msr_dw{tlbl_sel}}           & tlbl_q)    |
      ({msr_dw{tlbh_sel}}           & tlbh_q);

   // Unmapped banks read zero
   assign rd_mux = ({msr_dw{is_ps}} & dout_ps) | ({msr_dw{is_imm}} & dout_imm);

   assign wmsr_psr  = s_wmsr & is_ps & s_addr.ps.off[off_psr];
   assign wmsr_epsr = s_wmsr & is_ps & s_addr.ps.off[off_epsr];
   assign wmsr_epc  = s_wmsr & is_ps & s_addr.ps.off[off_epc];
   assign wmsr_elsa = s_wmsr & is_ps & s_addr.ps.off[off_elsa];

   assign exp_ent_c = s_commit & (s_syscall | s_ext_exp);
   assign pc_addr   = {s_pc, 2'b00};

   // Status fields, ALU flag first, then wmsr, then restore from EPSR on ret
   always_comb begin
      psr_nxt           = psr;
      psr_nxt[psr_cc]   = s_cc_we ? s_cc_nxt :
                          wmsr_psr ? s_wdata[psr_cc] : epsr[psr_cc];
      psr_nxt[psr_rm]   = wmsr_psr ? s_wdata[psr_rm] : epsr[psr_rm];
      psr_nxt[psr_ire]  = wmsr_psr ? s_wdata[psr_ire] : epsr[psr_ire];
      psr_nxt[psr_imme] = wmsr_psr ? s_wdata[psr_imme] : epsr[psr_imme];
      psr_nxt[psr_dmme] = wmsr_psr ? s_wdata[psr_dmme] : epsr[psr_dmme];
   end

   assign psr_field_we[0]   = s_commit & (s_ret | s_cc_we | wmsr_psr);
   assign psr_field_we[4:1] = {4{s_commit & (s_ret | wmsr_psr)}};

   // Exception entry saves the status word
   assign epsr_nxt = wmsr_epsr ? s_wdata[psr_dw-1:0] : psr;
   assign epsr_we  = exp_ent_c | (s_commit & wmsr_epsr);

   // Syscall returns past itself, an external exception retries the insn
   assign epc_nxt = wmsr_epc  ? s_wdata :
                    s_ext_exp ? pc_addr : pc_addr + 32'd4;
   assign epc_we  = s_commit & (s_ext_exp | s_syscall | wmsr_epc);

   assign elsa_nxt = s_let_lsa_pc ? pc_addr : s_wdata;
   assign elsa_we  = s_commit & (s_let_lsa_pc | wmsr_elsa);

   assign wdata   = s_wdata;
   assign tlbl_we = s_commit & s_wmsr & is_imm & tlbl_sel;
   assign tlbh_we = s_commit & s_wmsr & is_imm & tlbh_sel;

   always_ff @(posedge clk) begin
      if (reset) begin
         rd_valid <= 1'b0;
         exp_ent  <= 1'b0;
      end else begin
         rd_valid <= s_rmsr;
         exp_ent  <= exp_ent_c;
      end
   end

   always_ff @(posedge clk) begin
      if (s_rmsr)
         rd_data <= rd_mux;
   end

endmodule

`default_nettype wire

/* verilog/msr_file.sv */
// MSR register file
`timescale 1ns/1ps
`default_nettype none

module msr_file
   import msr_pkg::*;
(
   input  wire logic              clk,
   input  wire logic              reset,
   input  wire logic [psr_dw-1:0] psr_nxt,
   // Bit 0 cc, 1 rm, 2 ire, 3 imme, 4 dmme
   input  wire logic [4:0]        psr_field_we,
   input  wire logic [psr_dw-1:0] epsr_nxt,
   input  wire logic              epsr_we,
   input  wire logic [msr_dw-1:0] epc_nxt,
   input  wire logic              epc_we,
   input  wire logic [msr_dw-1:0] elsa_nxt,
   input  wire logic              elsa_we,
   input  wire logic [tlb_aw-1:0] tlb_idx,
   input  wire logic [msr_dw-1:0] wdata,
   input  wire logic              tlbl_we,
   input  wire logic              tlbh_we,
   output logic [psr_dw-1:0]      psr,
   output logic [psr_dw-1:0]      epsr,
   output logic [msr_dw-1:0]      epc,
   output logic [msr_dw-1:0]      elsa,
   output logic [msr_dw-1:0]      tlbl_q,
   output logic [msr_dw-1:0]      tlbh_q
);

   localparam int tlb_n = 1 << tlb_aw;

   logic [msr_dw-1:0] tlbl [tlb_n];
   logic [msr_dw-1:0] tlbh [tlb_n];

   // PSR, each writable field has its own enable
   // Reserved bits keep their reset value
   always_ff @(posedge clk) begin
      if (reset) begin
         psr <= psr_reset;
      end else begin
         if (psr_field_we[0])
            psr[psr_cc] <= psr_nxt[psr_cc];
         if (psr_field_we[1])
            psr[psr_rm] <= psr_nxt[psr_rm];
         if (psr_field_we[2])
            psr[psr_ire] <= psr_nxt[psr_ire];
         if (psr_field_we[3])
            psr[psr_imme] <= psr_nxt[psr_imme];
         if (psr_field_we[4])
            psr[psr_dmme] <= psr_nxt[psr_dmme];
      end
   end

   // Exception state
   always_ff @(posedge clk) begin
      if (reset) begin
         epsr <= '0;
         epc  <= '0;
         elsa <= '0;
      end else begin
         if (epsr_we)
            epsr <= epsr_nxt;
         if (epc_we)
            epc <= epc_nxt;
         if (elsa_we)
            elsa <= elsa_nxt;
      end
   end

   // Instruction TLB, low and high words
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < tlb_n; i++) begin
            tlbl[i] <= '0;
            tlbh[i] <= '0;
         end
      end else begin
         if (tlbl_we)
            tlbl[tlb_idx] <= wdata;
         if (tlbh_we)
            tlbh[tlb_idx] <= wdata;
      end
   end

   // Asynchronous read at the current index
   assign tlbl_q = tlbl[tlb_idx];
   assign tlbh_q = tlbh[tlb_idx];

endmodule

`default_nettype wire

/* verilog/msr_issue.sv */
// MSR issue stage
`timescale 1ns/1ps
`default_nettype none

module msr_issue
   import msr_pkg::*;
(
   input  wire logic              clk,
   input  wire logic              reset,
   input  wire logic              rmsr,
   input  wire logic              wmsr,
   input  wire logic [msr_dw-1:0] operand_1,
   input  wire logic [msr_dw-1:0] operand_2,
   input  wire logic [msr_dw-1:0] operand_3,
   input  wire logic              commit,
   input  wire logic              cc_we,
   input  wire logic              cc_nxt,
   input  wire logic              ret,
   input  wire logic              syscall,
   input  wire logic              ext_exp,
   input  wire logic              let_lsa_pc,
   input  wire logic [msr_dw-3:0] insn_pc,
   output msr_addr_t              s_addr,
   output logic                   s_rmsr,
   output logic                   s_wmsr,
   output logic [msr_dw-1:0]      s_wdata,
   output logic                   s_commit,
   output logic                   s_cc_we,
   output logic                   s_cc_nxt,
   output logic                   s_ret,
   output logic                   s_syscall,
   output logic                   s_ext_exp,
   output logic                   s_let_lsa_pc,
   output logic [msr_dw-3:0]      s_pc
);

   logic [msr_dw-1:0] addr_sum;

   // Base plus displacement
   assign addr_sum = operand_1 + operand_2;

   // Strobes
   always_ff @(posedge clk) begin
      if (reset) begin
         s_rmsr       <= 1'b0;
         s_wmsr       <= 1'b0;
         s_commit     <= 1'b0;
         s_cc_we      <= 1'b0;
         s_ret        <= 1'b0;
         s_syscall    <= 1'b0;
         s_ext_exp    <= 1'b0;
         s_let_lsa_pc <= 1'b0;
      end else begin
         s_rmsr       <= rmsr;
         s_wmsr       <= wmsr;
         s_commit     <= commit;
         s_cc_we      <= cc_we;
         s_ret        <= ret;
         s_syscall    <= syscall;
         s_ext_exp    <= ext_exp;
         s_let_lsa_pc <= let_lsa_pc;
      end
   end

   // Payload
   always_ff @(posedge clk) begin
      s_addr   <= addr_sum;
      s_wdata  <= operand_3;
      s_cc_nxt <= cc_nxt;
      s_pc     <= insn_pc;
   end

endmodule

`default_nettype wire

/* verilog/msr_pkg.sv */
// MSR subsystem shared definitions
`default_nettype none

package msr_pkg;

   // Widths
   localparam int msr_dw      = 32;
   localparam int psr_dw      = 10;
   localparam int tlb_aw      = 4;
   localparam int bank_aw     = 4;
   localparam int bank_off_aw = 9;

   // Bank numbers
   localparam logic [bank_aw-1:0] bank_ps  = 'd0;
   localparam logic [bank_aw-1:0] bank_imm = 'd1;

   // One-hot offset bits in the PS bank
   localparam int off_psr    = 0;
   localparam int off_cpuid  = 1;
   localparam int off_epsr   = 2;
   localparam int off_epc    = 3;
   localparam int off_elsa   = 4;
   localparam int off_coreid = 5;

   // Offset bits in the IMM bank
   localparam int off_tlbsel   = 8;
   localparam int off_tlbh_sel = 7;

   // Status word fields, other bits reserved
   localparam int psr_cc   = 0;
   localparam int psr_rm   = 4;
   localparam int psr_ire  = 5;
   localparam int psr_imme = 6;
   localparam int psr_dmme = 7;

   // Comes up in root mode
   localparam logic [psr_dw-1:0] psr_reset = 10'b00_0001_0000;

   // Read-only identification words
   localparam logic [msr_dw-1:0] cpuid_val  = 32'h4d53_0101;
   localparam logic [msr_dw-1:0] coreid_val = 32'h0000_0003;
   localparam logic [msr_dw-1:0] immid_val  = 32'h0000_0404;

   // MSR address word, seen either as a PS access or as an IMM TLB access
   typedef union packed {
      struct packed {
         logic [msr_dw-bank_aw-bank_off_aw-1:0] pad;
         logic [bank_aw-1:0]                    bank;
         logic [bank_off_aw-1:0]                off;
      } ps;
      struct packed {
         logic [msr_dw-bank_aw-bank_off_aw-1:0] pad;
         logic [bank_aw-1:0]                    bank;
         logic                                  tlbsel;
         logic                                  tlbh_sel;
         logic [bank_off_aw-tlb_aw-3:0]         rsvd;
         logic [tlb_aw-1:0]                     idx;
      } imm;
   } msr_addr_t;

endpackage

`default_nettype wire

/* verilog/msr_unit.sv */
// MSR unit top level
`timescale 1ns/1ps
`default_nettype none

module msr_unit
   import msr_pkg::*;
(
   input  wire logic              clk,
   input  wire logic              reset,
   input  wire logic              rmsr,
   input  wire logic              wmsr,
   input  wire logic [msr_dw-1:0] operand_1,
   input  wire logic [msr_dw-1:0] operand_2,
   input  wire logic [msr_dw-1:0] operand_3,
   input  wire logic              commit,
   input  wire logic              cc_we,
   input  wire logic              cc_nxt,
   input  wire logic              ret,
   input  wire logic              syscall,
   input  wire logic              ext_exp,
   input  wire logic              let_lsa_pc,
   input  wire logic [msr_dw-3:0] insn_pc,
   output logic [msr_dw-1:0]      rd_data,
   output logic                   rd_valid,
   output logic                   exp_ent,
   output logic [psr_dw-1:0]      psr,
   output logic [msr_dw-1:0]      epc
);

   // Issue to execute
   msr_addr_t         s_addr;
   logic              s_rmsr;
   logic              s_wmsr;
   logic [msr_dw-1:0] s_wdata;
   logic              s_commit;
   logic              s_cc_we;
   logic              s_cc_nxt;
   logic              s_ret;
   logic              s_syscall;
   logic              s_ext_exp;
   logic              s_let_lsa_pc;
   logic [msr_dw-3:0] s_pc;

   // Execute and register file
   logic [psr_dw-1:0] epsr;
   logic [msr_dw-1:0] elsa;
   logic [msr_dw-1:0] tlbl_q;
   logic [msr_dw-1:0] tlbh_q;
   logic [tlb_aw-1:0] tlb_idx;
   logic [psr_dw-1:0] psr_nxt;
   logic [4:0]        psr_field_we;
   logic [psr_dw-1:0] epsr_nxt;
   logic              epsr_we;
   logic [msr_dw-1:0] epc_nxt;
   logic              epc_we;
   logic [msr_dw-1:0] elsa_nxt;
   logic              elsa_we;
   logic              tlbl_we;
   logic              tlbh_we;
   logic [msr_dw-1:0] wdata;

   msr_issue issue0 (
      .clk          (clk),
      .reset        (reset),
      .rmsr         (rmsr),
      .wmsr         (wmsr),
      .operand_1    (operand_1),
      .operand_2    (operand_2),
      .operand_3    (operand_3),
      .commit       (commit),
      .cc_we        (cc_we),
      .cc_nxt       (cc_nxt),
      .ret          (ret),
      .syscall      (syscall),
      .ext_exp      (ext_exp),
      .let_lsa_pc   (let_lsa_pc),
      .insn_pc      (insn_pc),
      .s_addr       (s_addr),
      .s_rmsr       (s_rmsr),
      .s_wmsr       (s_wmsr),
      .s_wdata      (s_wdata),
      .s_commit     (s_commit),
      .s_cc_we      (s_cc_we),
      .s_cc_nxt     (s_cc_nxt),
      .s_ret        (s_ret),
      .s_syscall    (s_syscall),
      .s_ext_exp    (s_ext_exp),
      .s_let_lsa_pc (s_let_lsa_pc),
      .s_pc         (s_pc)
   );

   msr_eu eu0 (
      .clk          (clk),
      .reset        (reset),
      .s_addr       (s_addr),
      .s_rmsr       (s_rmsr),
      .s_wmsr       (s_wmsr),
      .s_wdata      (s_wdata),
      .s_commit     (s_commit),
      .s_cc_we      (s_cc_we),
      .s_cc_nxt     (s_cc_nxt),
      .s_ret        (s_ret),
      .s_syscall    (s_syscall),
      .s_ext_exp    (s_ext_exp),
      .s_let_lsa_pc (s_let_lsa_pc),
      .s_pc         (s_pc),
      .psr          (psr),
      .epsr         (epsr),
      .epc          (epc),
      .elsa         (elsa),
      .tlbl_q       (tlbl_q),
      .tlbh_q       (tlbh_q),
      .tlb_idx      (tlb_idx),
      .psr_nxt      (psr_nxt),
      .psr_field_we (psr_field_we),
      .epsr_nxt     (epsr_nxt),
      .epsr_we      (epsr_we),
      .epc_nxt      (epc_nxt),
      .epc_we       (epc_we),
      .elsa_nxt     (elsa_nxt),
      .elsa_we      (elsa_we),
      .tlbl_we      (tlbl_we),
      .tlbh_we      (tlbh_we),
      .wdata        (wdata),
      .rd_data      (rd_data),
      .rd_valid     (rd_valid),
      .exp_ent      (exp_ent)
   );

   msr_file file0 (
      .clk          (clk),
      .reset        (reset),
      .psr_nxt      (psr_nxt),
      .psr_field_we (psr_field_we),
      .epsr_nxt     (epsr_nxt),
      .epsr_we      (epsr_we),
      .epc_nxt      (epc_nxt),
      .epc_we       (epc_we),
      .elsa_nxt     (elsa_nxt),
      .elsa_we      (elsa_we),
      .tlb_idx      (tlb_idx),
      .wdata        (wdata),
      .tlbl_we      (tlbl_we),
      .tlbh_we      (tlbh_we),
      .psr          (psr),
      .epsr         (epsr),
      .epc          (epc),
      .elsa         (elsa),
      .tlbl_q       (tlbl_q),
      .tlbh_q       (tlbh_q)
   );

endmodule

`default_nettype wire
